// ==== uopPkg.sv ====
// Shared types for the micro-op sequencer; ARM word size, register count and field positions are fixed
package uopPkg;

	// Vector types
	typedef logic [31:0] instrWord;	// One ARM instruction word
	typedef logic [15:0] regList;	// LDM register list, bit n selects Rn
	typedef logic [3:0]  regIndex;	// Register number
	typedef logic [3:0]  condCode;	// Condition field, bits 31:28
	typedef logic [3:0]  flagSet;	// {N, Z, C, V}
	typedef logic [3:0]  rzCtrl;	// {RA1 mux, WA3 Rz, RA2 Rz, RA1 Rz}
	typedef logic [3:0]  dpOpcode;	// Data processing opcode, bits 24:21

	// Result of classifying the instruction in decode
	typedef enum logic [2:0] {
		kindNone,	// Passes through untouched
		kindRsr,	// Register-shifted-register data processing
		kindMla,	// Multiply-accumulate, short or long
		kindBl,		// Branch with link
		kindLdm		// Load multiple, non-empty list
	} uopKind;

	// Sequencer state
	typedef enum logic [2:0] {
		ready,		// Idle or first step of an expansion
		rsrSecond,	// Operation using Rz
		mlaSecond,	// Accumulate step
		blSecond,	// Branch without link
		ldmNext		// Second and later loads
	} uopState;

	// Register encodings
	localparam regIndex rzReg   = 4'd15;	// Rz as seen inside a micro-op
	localparam regIndex linkReg = 4'd14;
	localparam regIndex pcReg   = 4'd15;

	// Address step between consecutive LDM words
	localparam logic [11:0] wordBytes = 12'd4;

	// Opcodes used to build micro-ops
	localparam dpOpcode movOp = 4'b1101;
	localparam dpOpcode addOp = 4'b0100;

	// Bits 27:4 of BX, excluded from the RSR class
	localparam logic [23:0] bxPattern = 24'h12fff1;

	// Instruction class fields
	localparam logic [2:0] dpClass     = 3'b000;	// Data processing, register form
	localparam logic [2:0] dpImmClass  = 3'b001;	// Data processing, immediate form
	localparam logic [2:0] lsImmClass  = 3'b010;	// Single load/store, immediate offset
	localparam logic [2:0] lsRegClass  = 3'b011;	// Single load/store, register offset
	localparam logic [2:0] ldmClass    = 3'b100;	// Block transfer
	localparam logic [3:0] blClass     = 4'b1011;	// Branch, link bit set
	localparam logic [3:0] mulPattern  = 4'b1001;	// Bits 7:4 of every multiply

endpackage

// ==== condCheck.sv ====
// Pure combinational ARM condition decode; code 15 is treated as always, flags must be stable in decode
`timescale 1ns/10ps

module condCheck import uopPkg::*; (
	input  condCode cond,		// Bits 31:28 of the instruction
	input  flagSet  flags,		// {N, Z, C, V}
	output logic    condPass	// High when the instruction would execute
);

	logic n;
	logic z;
	logic c;
	logic v;

	assign {n, z, c, v} = flags;	// Unpack in architectural order

	always_comb begin
		case (cond)
			4'h0: condPass = z;			// EQ
			4'h1: condPass = ~z;			// NE
			4'h2: condPass = c;			// CS/HS
			4'h3: condPass = ~c;			// CC/LO
			4'h4: condPass = n;			// MI
			4'h5: condPass = ~n;			// PL
			4'h6: condPass = v;			// VS
			4'h7: condPass = ~v;			// VC
			4'h8: condPass = c & ~z;		// HI
			4'h9: condPass = ~c | z;		// LS
			4'ha: condPass = (n == v);		// GE
			4'hb: condPass = (n != v);		// LT
			4'hc: condPass = ~z & (n == v);	// GT
			4'hd: condPass = z | (n != v);	// LE
			default: condPass = 1'b1;		// AL, and 15 as always
		endcase
	end

endmodule

// ==== ldmRegSelect.sv ====
// LDM list tracker; assumes instr is held for the whole run, offsets are only meaningful for a non-empty list
`timescale 1ns/10ps

module ldmRegSelect import uopPkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        stallUop,		// Pipeline back-pressure, holds the list
	input  instrWord    instr,
	input  uopState     state,
	output regIndex     nextReg,		// Register loaded on this step
	output logic        lastCycle,		// Exactly one register left
	output logic [11:0] startOffset,	// Offset of the first load from Rn
	output logic        addUp			// U bit of the first load
);

	regList     listNow;		// Registers still to load
	regList     curList;		// List this step works from
	regList     listNext;		// Current list minus the selected bit
	logic [4:0] curCount;
	logic [4:0] bitCount;		// Registers in the original list

	// First step reads the list straight from the instruction
	assign curList  = (state == ready) ? instr[15:0] : listNow;
	assign listNext = curList & (curList - 16'd1);	// Drop lowest set bit
	assign curCount = 5'($countones(curList));
	assign bitCount = 5'($countones(instr[15:0]));
	assign lastCycle = (curCount == 5'd1);

	// Lowest set register goes first, so loads run in ascending order
	always_comb begin
		nextReg = '0;
		for (int i = 15; i >= 0; i--) begin
			if (curList[i])
				nextReg = regIndex'(i);
		end
	end

	// Start address relative to Rn from the P and U bits
	always_comb begin
		case (instr[24:23])
			2'b00: begin				// DA, lowest word at Rn - 4(N-1)
				startOffset = wordBytes * 12'(bitCount - 5'd1);
				addUp = 1'b0;
			end
			2'b01: begin				// IA, first word at Rn
				startOffset = '0;
				addUp = 1'b1;
			end
			2'b10: begin				// DB, lowest word at Rn - 4N
				startOffset = wordBytes * 12'(bitCount);
				addUp = 1'b0;
			end
			default: begin				// IB, first word at Rn + 4
				startOffset = wordBytes;
				addUp = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			listNow <= '0;
		else if (!stallUop)
			listNow <= listNext;		// Holds under back-pressure
	end

endmodule

// ==== uopFsm.sv ====
// Mealy sequencer control; instr must stay constant while uopStall is high, stallUop freezes the state
`timescale 1ns/10ps

module uopFsm import uopPkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     stallUop,		// Back-pressure from the pipeline
	input  instrWord instr,
	input  logic     condPass,		// Condition of the current instruction
	input  logic     lastCycle,		// From the LDM list tracker
	output uopState  state,
	output uopKind   kind,
	output logic     instrMux,		// Select micro-op over the fetched word
	output logic     noFlagUpdate,
	output logic     uopStall,		// Stall fetch while more steps follow
	output logic     ldmForward,
	output logic     prevRsr,
	output logic     keepV,
	output rzCtrl    regFileRz
);

	uopState stateNext;
	logic    isRsr;
	logic    isMla;
	logic    isBl;
	logic    isLdm;

	// Classifier
	assign isRsr = (instr[27:25] == dpClass) & ~instr[7] & instr[4]
		& (instr[27:4] != bxPattern);
	assign isMla = instr[21] & (instr[7:4] == mulPattern);
	assign isBl  = (instr[27:24] == blClass);
	assign isLdm = (instr[27:25] == ldmClass) & instr[20] & (instr[15:0] != '0);

	always_comb begin
		if (isRsr)
			kind = kindRsr;
		else if (isMla)
			kind = kindMla;
		else if (isBl)
			kind = kindBl;
		else if (isLdm)
			kind = kindLdm;
		else
			kind = kindNone;
	end

	always_comb begin
		stateNext    = ready;
		instrMux     = 1'b0;
		noFlagUpdate = 1'b0;
		uopStall     = 1'b0;
		ldmForward   = 1'b0;
		prevRsr      = 1'b0;
		keepV        = 1'b0;
		regFileRz    = 4'b0000;
		case (state)
			ready: begin
				case (kind)
					kindRsr: begin			// MOV Rz first
						stateNext    = rsrSecond;
						instrMux     = 1'b1;
						noFlagUpdate = 1'b1;
						uopStall     = 1'b1;
						regFileRz    = 4'b1100;
					end
					kindMla: begin			// MUL into Rz first
						stateNext = mlaSecond;
						instrMux  = 1'b1;
						uopStall  = 1'b1;
						keepV     = 1'b1;		// Multiply leaves V alone
						regFileRz = 4'b1100;
					end
					kindBl: begin			// MOV R14, R15 first
						stateNext = blSecond;
						instrMux  = 1'b1;
						uopStall  = 1'b1;
					end
					kindLdm: begin			// First load, single register ends here
						stateNext    = lastCycle ? ready : ldmNext;
						instrMux     = 1'b1;
						noFlagUpdate = 1'b1;
						uopStall     = ~lastCycle;
					end
					default: ;				// Plain pass-through
				endcase
			end
			rsrSecond: begin
				instrMux  = 1'b1;
				prevRsr   = 1'b1;
				regFileRz = 4'b0010;		// Rz on read port 2
			end
			mlaSecond: begin
				instrMux     = 1'b1;
				noFlagUpdate = 1'b1;
				prevRsr      = 1'b1;
				regFileRz    = instr[23] ? 4'b0000 : 4'b0001;	// Short form reads Rz on port 1
			end
			blSecond: instrMux = 1'b1;
			ldmNext: begin
				noFlagUpdate = 1'b1;
				if (condPass) begin
					stateNext  = lastCycle ? ready : ldmNext;
					instrMux   = 1'b1;
					uopStall   = ~lastCycle;
					ldmForward = 1'b1;		// Address comes from the previous load
				end
				// Failed condition cancels the run with mux low
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= ready;
		else if (!stallUop)
			state <= stateNext;
	end

endmodule

// ==== uopEncoder.sv ====
// Micro-op word builder; purely combinational, relies on instr being held during an expansion
`timescale 1ns/10ps

module uopEncoder import uopPkg::*; (
	input  instrWord    instr,
	input  uopState     state,
	input  uopKind      kind,
	input  logic        condPass,		// Only consulted on later LDM steps
	input  regIndex     nextReg,
	input  logic [11:0] startOffset,
	input  logic        addUp,
	output instrWord    uopInstr
);

	condCode cond;

	assign cond = instr[31:28];		// Every micro-op keeps the original condition

	always_comb begin
		uopInstr = instr;				// Pass-through unless expanded
		case (state)
			ready: begin
				case (kind)
					kindRsr: uopInstr = {instr[31:25],	// Cond, register form
						movOp, 1'b0,					// MOV, S clear
						4'b0000, rzReg,					// SBZ, Rd = Rz
						instr[11:0]};					// Rs shift of Rm kept
					kindMla: uopInstr = {instr[31:24],
						1'b0, instr[22], 1'b0, 1'b0,	// Plain MUL, sign kept, S clear
						rzReg, 4'b0000,					// Rd = Rz, SBZ
						instr[11:0]};					// Rs and Rm
					kindBl: uopInstr = {cond, dpClass,
						movOp, 1'b0,
						4'b0000, linkReg,				// R14 destination
						8'b0, pcReg};					// Unshifted R15 source
					kindLdm: uopInstr = {cond, lsImmClass,
						1'b1, addUp,					// Pre-index, direction from mode
						1'b0, 1'b0,						// Word access, no writeback
						instr[20], instr[19:16],		// L bit, same base
						nextReg, startOffset};
					default: ;
				endcase
			end
			rsrSecond: uopInstr = {instr[31:12],
				8'b0, rzReg};						// Rz unshifted as operand 2
			mlaSecond: begin
				if (instr[23])						// Long form, RdLo fed back as Rs
					uopInstr = {instr[31:12], instr[15:12], mulPattern, instr[19:16]};
				else
					uopInstr = {cond, dpClass,
						addOp, instr[20],				// ADD, original S bit
						rzReg, instr[19:16],			// Rn = Rz, Rd kept
						8'b0, instr[15:12]};			// Accumulator as Rm
			end
			blSecond: uopInstr = {instr[31:25], 1'b0, instr[23:0]};	// Link bit cleared
			ldmNext: begin
				if (condPass)
					uopInstr = {cond, lsRegClass,
						1'b1, 1'b1, 1'b0, 1'b0,			// Pre-index, add, word, no writeback
						instr[20], rzReg,				// Base is Rz
						nextReg, 8'b0, rzReg};			// Rm slot decodes as the word step
				else
					uopInstr = {cond, dpImmClass,
						addOp, 1'b0, 20'b0};			// R0 = R0 + 0, never executes
			end
			default: ;
		endcase
	end

endmodule

// ==== uopSequencer.sv ====
// Decode-stage micro-op sequencer top; fetch must hold instr while uopStall is high
`timescale 1ns/10ps

module uopSequencer import uopPkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     stallUop,		// Holds sequencer state
	input  instrWord instr,			// Decoded instruction word
	input  flagSet   flags,			// {N, Z, C, V}
	output instrWord uopInstr,
	output logic     instrMux,
	output logic     noFlagUpdate,
	output logic     uopStall,
	output logic     ldmForward,
	output logic     prevRsr,
	output logic     keepV,
	output rzCtrl    regFileRz
);

	uopState     state;
	uopKind      kind;
	logic        condPass;
	regIndex     nextReg;
	logic        lastCycle;
	logic [11:0] startOffset;
	logic        addUp;

	condCheck condCheck_i (
		.cond     (instr[31:28]),
		.flags    (flags),
		.condPass (condPass)
	);

	ldmRegSelect ldmRegSelect_i (
		.clk         (clk),
		.reset       (reset),
		.stallUop    (stallUop),
		.instr       (instr),
		.state       (state),
		.nextReg     (nextReg),
		.lastCycle   (lastCycle),
		.startOffset (startOffset),
		.addUp       (addUp)
	);

	uopFsm uopFsm_i (
		.clk          (clk),
		.reset        (reset),
		.stallUop     (stallUop),
		.instr        (instr),
		.condPass     (condPass),
		.lastCycle    (lastCycle),
		.state        (state),
		.kind         (kind),
		.instrMux     (instrMux),
		.noFlagUpdate (noFlagUpdate),
		.uopStall     (uopStall),
		.ldmForward   (ldmForward),
		.prevRsr      (prevRsr),
		.keepV        (keepV),
		.regFileRz    (regFileRz)
	);

	uopEncoder uopEncoder_i (
		.instr       (instr),
		.state       (state),
		.kind        (kind),
		.condPass    (condPass),
		.nextReg     (nextReg),
		.startOffset (startOffset),
		.addUp       (addUp),
		.uopInstr    (uopInstr)
	);

endmodule

// ==== uopSequencer_sva.sv ====
// Assertions bound into uopFsm; single clock, synchronous active-high reset
`timescale 1ns/10ps

module uopSequencer_sva import uopPkg::*; (
	input logic    clk,
	input logic    reset,
	input logic    stallUop,
	input uopState state,
	input uopKind  kind,
	input logic    instrMux,
	input logic    uopStall
);

	// A completed step leaves the FSM in ready where a plain word passes through
	noMuxForPlain: assert property (@(posedge clk) disable iff (reset)
		(!stallUop && !uopStall) |=> (state == ready && (kind != kindNone || !instrMux)))
		else $error("plain word not passed through after a completed step");

	// Back-pressure freezes the sequencer
	stateHoldsUnderStall: assert property (@(posedge clk) disable iff (reset)
		stallUop |=> (state == $past(state)))
		else $error("state changed while stallUop was high");

	// First cycle out of reset
	noStallAfterReset: assert property (@(posedge clk)
		($past(reset) && !reset && kind == kindNone) |-> !uopStall)
		else $error("uopStall high right after reset for a pass-through instruction");

endmodule

bind uopFsm uopSequencer_sva uopSequencer_sva_i (
	.clk      (clk),
	.reset    (reset),
	.stallUop (stallUop),
	.state    (state),
	.kind     (kind),
	.instrMux (instrMux),
	.uopStall (uopStall)
);

// ==== uopSequencer_tb.sv ====
// Random testbench for the micro-op sequencer; fixed xorshift seed, instr held while uopStall is high
`timescale 1ns/10ps

module uopSequencer_tb import uopPkg::*; ();

	localparam int resetCycles = 16;
	localparam int testCycles  = 400;		// Cycles per test
	localparam int numTests    = 5;
	localparam int timeoutNs   = (resetCycles + numTests * testCycles) * 8 * 2 + 1000;

	logic     clk;
	logic     reset;
	logic     stallUop;
	instrWord instr;
	flagSet   flags;
	instrWord uopInstr;
	logic     instrMux;
	logic     noFlagUpdate;
	logic     uopStall;
	logic     ldmForward;
	logic     prevRsr;
	logic     keepV;
	rzCtrl    regFileRz;

	logic [31:0] rngState;
	int          checkCount;
	int          errorCount;
	int          cancelCount;		// Cancelled LDM steps seen
	logic        holdInstr;			// Fetch is stalled so instr is kept

	// Reference model state and expected outputs
	uopState  mState;
	regList   mList;
	uopState  expNext;
	regList   expListNext;
	instrWord expWord;
	logic     expMux;
	logic     expNfu;
	logic     expStall;
	logic     expFwd;
	logic     expPrev;
	logic     expKeepV;
	rzCtrl    expRz;
	logic     expCancel;

	uopSequencer uopSequencer_i (
		.clk          (clk),
		.reset        (reset),
		.stallUop     (stallUop),
		.instr        (instr),
		.flags        (flags),
		.uopInstr     (uopInstr),
		.instrMux     (instrMux),
		.noFlagUpdate (noFlagUpdate),
		.uopStall     (uopStall),
		.ldmForward   (ldmForward),
		.prevRsr      (prevRsr),
		.keepV        (keepV),
		.regFileRz    (regFileRz)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;		// 8 ns period
	end

	// Watchdog allows twice the expected run length plus margin
	initial begin
		#timeoutNs;
		$display("Timeout: the tests did not finish within %0d ns", timeoutNs);
		$display("SIMULATION FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// ARM condition rules where odd codes invert the even ones below 14
	function automatic logic condHolds(input condCode c, input flagSet f);
		logic n;
		logic z;
		logic cy;
		logic v;
		logic base;
		{n, z, cy, v} = f;
		case (c[3:1])
			3'd0: base = z;
			3'd1: base = cy;
			3'd2: base = n;
			3'd3: base = v;
			3'd4: base = cy && !z;
			3'd5: base = (n == v);
			3'd6: base = !z && (n == v);
			default: return 1'b1;			// AL and 15
		endcase
		return c[0] ? !base : base;
	endfunction

	function automatic uopKind classify(input instrWord w);
		logic bx;
		bx = (w[27:4] == 24'h12fff1);
		if (w[27:25] == 3'b000 && !w[7] && w[4] && !bx)
			return kindRsr;
		if (w[21] && w[7:4] == 4'b1001)
			return kindMla;
		if (w[27:24] == 4'b1011)
			return kindBl;
		if (w[27:25] == 3'b100 && w[20] && w[15:0] != 16'h0)
			return kindLdm;
		return kindNone;
	endfunction

	// Random instruction for a test biased toward the expanding kinds
	function automatic instrWord pickInstr(input int testId);
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] t;
		logic [2:0]  sel;
		regList      list;
		condCode     cond;
		r = nextRand();
		s = nextRand();
		t = nextRand();
		case (testId)
			1: sel = 3'd0;
			2: sel = 3'd1 + {1'b0, s[1:0]};		// RSR, short MLA, long MLA, BL
			3, 4: sel = 3'd5;
			default: sel = (s[2:0] > 3'd5) ? 3'd5 : s[2:0];
		endcase
		cond = (testId == 3) ? 4'he : r[31:28];
		list = t[15:0] & t[31:16];				// Sparse lists keep runs short
		if (list == 16'h0)
			list = 16'h1 << t[3:0];
		case (sel)
			3'd0: begin
				if (s[8])						// LDM with an empty list
					return {r[31:28], 3'b100, r[24:21], 1'b1, r[19:16], 16'h0};
				return {r[31:28], 3'b001, r[24:22], 1'b0, r[20:0]};
			end
			3'd1: return {r[31:28], 3'b000, r[24:8], 1'b0, r[6:5], 1'b1, r[3:0]};
			3'd2: return {r[31:28], 4'b0000, 1'b0, r[22], 1'b1, r[20:8], 4'b1001, r[3:0]};
			3'd3: return {r[31:28], 4'b0000, 1'b1, r[22], 1'b1, r[20:8], 4'b1001, r[3:0]};
			3'd4: return {r[31:28], 4'b1011, r[23:0]};
			default: return {cond, 3'b100, r[24:21], 1'b1, r[19:16], list};
		endcase
	endfunction

	task automatic computeExpected();
		uopKind      k;
		regList      work;
		int          count;
		int          total;
		logic        found;
		regIndex     low;
		logic        last;
		logic        pass;
		logic [11:0] offset;
		logic        up;
		k = classify(instr);
		pass = condHolds(instr[31:28], flags);
		work = (mState == ready) ? instr[15:0] : mList;	// First step reads the word
		count = 0;
		total = 0;
		found = 1'b0;
		low = '0;
		for (int i = 0; i < 16; i++) begin
			total += instr[i];
			if (work[i]) begin
				count++;
				if (!found)
					low = regIndex'(i);		// Lowest listed register
				found = 1'b1;
			end
		end
		last = (count == 1);
		expListNext = work;
		expListNext[low] = 1'b0;
		case (instr[24:23])
			2'b00: begin
				offset = 12'(4 * (total - 1));
				up = 1'b0;
			end
			2'b01: begin
				offset = 12'd0;
				up = 1'b1;
			end
			2'b10: begin
				offset = 12'(4 * total);
				up = 1'b0;
			end
			default: begin
				offset = 12'd4;
				up = 1'b1;
			end
		endcase
		expWord = instr;
		{expMux, expNfu, expStall, expFwd, expPrev, expKeepV, expCancel} = '0;
		expRz = 4'b0000;
		expNext = ready;
		case (mState)
			ready: begin
				if (k == kindRsr) begin		// MOV Rz, Rm shifted by Rs
					expWord[24:21] = 4'b1101;
					expWord[20] = 1'b0;
					expWord[19:16] = 4'h0;
					expWord[15:12] = 4'hf;
					{expMux, expNfu, expStall} = 3'b111;
					expRz = 4'b1100;
					expNext = rsrSecond;
				end else if (k == kindMla) begin	// MUL Rz
					expWord[23] = 1'b0;
					expWord[21:20] = 2'b00;
					expWord[19:16] = 4'hf;
					expWord[15:12] = 4'h0;
					{expMux, expStall, expKeepV} = 3'b111;
					expRz = 4'b1100;
					expNext = mlaSecond;
				end else if (k == kindBl) begin		// MOV R14, R15
					expWord = {instr[31:28], 28'h1a0e00f};
					{expMux, expStall} = 2'b11;
					expNext = blSecond;
				end else if (k == kindLdm) begin
					expWord = {instr[31:28], 3'b010, 1'b1, up, 2'b00, 1'b1, instr[19:16],
						low, offset};
					{expMux, expNfu} = 2'b11;
					expStall = !last;
					expNext = last ? ready : ldmNext;
				end
			end
			rsrSecond: begin
				expWord = {instr[31:12], 12'h00f};
				{expMux, expPrev} = 2'b11;
				expRz = 4'b0010;
			end
			mlaSecond: begin
				if (instr[23])
					expWord = {instr[31:12], instr[15:12], 4'b1001, instr[19:16]};
				else
					expWord = {instr[31:28], 7'b0000100, instr[20], 4'hf, instr[19:16],
						8'h00, instr[15:12]};
				{expMux, expNfu, expPrev} = 3'b111;
				expRz = instr[23] ? 4'b0000 : 4'b0001;
			end
			blSecond: begin
				expWord[24] = 1'b0;
				expMux = 1'b1;
			end
			default: begin				// Later LDM steps
				expNfu = 1'b1;
				if (pass) begin
					expWord = {instr[31:28], 7'b0111100, 1'b1, 4'hf, low, 8'h00, 4'hf};
					{expMux, expFwd} = 2'b11;
					expStall = !last;
					expNext = last ? ready : ldmNext;
				end else begin
					expWord = {instr[31:28], 28'h2800000};	// Never executes
					expCancel = 1'b1;
				end
			end
		endcase
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic runTest(input int testId, input string label);
		logic [31:0] r;
		int          errorsBefore;
		int          cancelsBefore;
		errorsBefore = errorCount;
		cancelsBefore = cancelCount;
		for (int c = 0; c < testCycles; c++) begin
			@(negedge clk);
			r = nextRand();
			if (!holdInstr)
				instr = pickInstr(testId);
			if (!(testId == 5 && stallUop))
				flags = r[7:4];				// Held under stall in the back-pressure test
			stallUop = (testId == 5) ? r[9] : (r[11:10] == 2'b00);
			#3;								// Settled just before the rising edge
			computeExpected();
			checkValue("uopInstr", uopInstr, expWord);
			checkValue("instrMux", instrMux, expMux);
			checkValue("noFlagUpdate", noFlagUpdate, expNfu);
			checkValue("uopStall", uopStall, expStall);
			checkValue("ldmForward", ldmForward, expFwd);
			checkValue("prevRsr", prevRsr, expPrev);
			checkValue("keepV", keepV, expKeepV);
			checkValue("regFileRz", regFileRz, expRz);
			if (expCancel && !stallUop)
				cancelCount++;
			holdInstr = stallUop | expStall;
			if (!stallUop) begin
				mState = expNext;
				mList = expListNext;
			end
		end
		if (testId == 4 && cancelCount == cancelsBefore) begin
			errorCount++;
			$display("Test 4 never saw an LDM run cancelled by a failed condition");
		end
		$display("Test %0d %s: %0d cycles, %0d errors", testId, label, testCycles,
			errorCount - errorsBefore);
	endtask

	initial begin
		rngState = 32'hd9b2;
		reset = 1'b1;
		stallUop = 1'b0;
		instr = '0;
		flags = '0;
		checkCount = 0;
		errorCount = 0;
		cancelCount = 0;
		holdInstr = 1'b0;
		mState = ready;
		mList = '0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		runTest(1, "pass-through");
		runTest(2, "two-step expansions");
		runTest(3, "LDM runs");
		runTest(4, "LDM cancel");
		runTest(5, "back-pressure");
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
uopPkg.sv
condCheck.sv
ldmRegSelect.sv
uopFsm.sv
uopEncoder.sv
uopSequencer.sv
uopSequencer_sva.sv
uopSequencer_tb.sv
